//--- design/tlb_config.svh
`ifndef TLB_CONFIG_SVH
`define TLB_CONFIG_SVH

// --------------------
// tlb geometry
// --------------------

// number of entries, power of two only
`define TLB_ENTRIES 32

// linear and physical address width
`define TLB_ADDR_W 32

// 4 KiB pages
`define TLB_OFFSET_W 12

// page number width, tag and frame
`define TLB_PAGE_W (`TLB_ADDR_W - `TLB_OFFSET_W)

`endif

//--- design/tlb_pkg.sv
`include "tlb_config.svh"

package tlb_pkg;

    localparam int TLB_INDEX_W = $clog2(`TLB_ENTRIES);

    typedef logic [`TLB_ADDR_W-1:0]  tlb_addr_t;
    typedef logic [`TLB_PAGE_W-1:0]  tlb_page_t;
    typedef logic [TLB_INDEX_W-1:0]  tlb_index_t;
    typedef logic [`TLB_ENTRIES-1:0] tlb_mask_t;

    // page attributes, rw and su already combined over pde and pte
    typedef struct packed {
        logic pwt;
        logic pcd;
        logic combined_rw;
        logic combined_su;
    } tlb_attr_t;

    typedef struct packed {
        logic      dirty;   // set when the walk was for a write
        tlb_attr_t attr;
        logic      valid;
        tlb_page_t page;    // physical page
        tlb_page_t tag;     // linear page
    } tlb_entry_t;

    typedef struct packed {
        logic      write_do;
        tlb_addr_t linear;
        tlb_addr_t physical;
        tlb_attr_t attr;
        logic      dirty;
    } tlb_write_req_t;

    typedef struct packed {
        logic      translate_do;
        tlb_addr_t linear;
        logic      rw;      // 1 for a write access
    } tlb_translate_req_t;

    typedef struct packed {
        logic      valid;
        tlb_addr_t physical;
        tlb_attr_t attr;
    } tlb_translate_rsp_t;

endpackage

//--- design/tlb_fill_select.sv
`timescale 1ns/1ns

`include "tlb_config.svh"

module tlb_fill_select import tlb_pkg::*; (
    input  tlb_write_req_t write_req,
    input  tlb_mask_t      valid_mask,
    input  tlb_index_t     victim_index,
    output tlb_mask_t      write_onehot,
    output tlb_entry_t     write_entry,
    output logic           write_touch,
    output tlb_index_t     write_index
);

    logic       free_found;
    tlb_index_t free_index;

    // --------------------
    // lowest free slot
    // --------------------

    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!valid_mask[i] && !free_found) begin
                free_found = 1'b1;
                free_index = tlb_index_t'(i);
            end
        end
    end

    // full buffer falls back to the plru victim
    assign write_index = free_found ? free_index : victim_index;

    assign write_touch  = write_req.write_do;
    assign write_onehot = write_req.write_do ? (tlb_mask_t'(1) << write_index) : '0;

    // --------------------
    // entry packing
    // --------------------

    always_comb begin
        write_entry       = '0;
        write_entry.dirty = write_req.dirty;
        write_entry.attr  = write_req.attr;
        write_entry.valid = 1'b1;
        write_entry.page  = write_req.physical[`TLB_ADDR_W-1:`TLB_OFFSET_W];
        write_entry.tag   = write_req.linear[`TLB_ADDR_W-1:`TLB_OFFSET_W];
    end

endmodule

//--- design/tlb_plru_tree.sv
`timescale 1ns/1ns

`include "tlb_config.svh"

module tlb_plru_tree import tlb_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush_all,
    input  logic       write_touch,
    input  tlb_index_t write_index,
    input  logic       hit_touch,
    input  tlb_index_t hit_index,
    output tlb_index_t victim_index
);

    // heap order: node n has children 2n+1 (left) and 2n+2 (right),
    // leaves of the last level map onto entries in index order
    typedef logic [`TLB_ENTRIES-2:0] plru_t;

    plru_t plru_bits;

    // --------------------
    // tree walks
    // --------------------

    // follow the bits from the root, 0 left and 1 right
    function automatic tlb_index_t plru_victim(plru_t bits);
        tlb_index_t idx;
        int         node;
        idx  = '0;
        node = 0;
        for (int lvl = 0; lvl < TLB_INDEX_W; lvl++) begin
            idx[TLB_INDEX_W-1-lvl] = bits[node];
            node = 2 * node + 1 + int'(bits[node]);
        end
        return idx;
    endfunction

    // every node on the path is turned to point away from idx
    function automatic plru_t plru_touch(plru_t bits, tlb_index_t idx);
        plru_t result;
        int    node;
        logic  dir;
        result = bits;
        node   = 0;
        for (int lvl = 0; lvl < TLB_INDEX_W; lvl++) begin
            dir          = idx[TLB_INDEX_W-1-lvl];
            result[node] = ~dir;    // 1 when idx sits in the left half
            node         = 2 * node + 1 + int'(dir);
        end
        return result;
    endfunction

    assign victim_index = plru_victim(plru_bits);

    // --------------------
    // state update
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plru_bits <= '0;
        end else if (flush_all) begin
            plru_bits <= '0;
        end else if (write_touch) begin
            plru_bits <= plru_touch(plru_bits, write_index);  // write wins
        end else if (hit_touch) begin
            plru_bits <= plru_touch(plru_bits, hit_index);
        end
    end

endmodule

//--- design/tlb_entry_array.sv
`timescale 1ns/1ns

`include "tlb_config.svh"

module tlb_entry_array import tlb_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush_single,
    input  tlb_addr_t          flush_address,
    input  logic               flush_all,
    input  tlb_mask_t          write_onehot,
    input  tlb_entry_t         write_entry,
    input  tlb_translate_req_t translate_req,
    input  logic               dirty_refuse,
    output tlb_entry_t         entries [`TLB_ENTRIES],
    output tlb_mask_t          valid_mask,
    output tlb_mask_t          hit_onehot
);

    tlb_entry_t entry_q [`TLB_ENTRIES];

    tlb_page_t  lookup_page;
    tlb_page_t  flush_page;
    tlb_mask_t  kill_mask;      // single flush or refused hit

    assign lookup_page = translate_req.linear[`TLB_ADDR_W-1:`TLB_OFFSET_W];
    assign flush_page  = flush_address[`TLB_ADDR_W-1:`TLB_OFFSET_W];

    // --------------------
    // tag match
    // --------------------

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            valid_mask[i] = entry_q[i].valid;
            hit_onehot[i] = translate_req.translate_do && entry_q[i].valid
                            && (entry_q[i].tag == lookup_page);
        end
    end

    // the refused entry is dropped so the walker can fetch it again
    // with the dirty bit set
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            kill_mask[i] = (flush_single && (entry_q[i].tag == flush_page))
                           || (dirty_refuse && hit_onehot[i]);
        end
    end

    // --------------------
    // storage
    // --------------------

    // only valid is cleared, payload bits stay as they were
    always_ff @(posedge clk) begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!rst_n) begin
                entry_q[i].valid <= 1'b0;
            end else if (flush_all || kill_mask[i]) begin
                entry_q[i].valid <= 1'b0;
            end else if (write_onehot[i]) begin
                entry_q[i] <= write_entry;
            end
        end
    end

    assign entries = entry_q;

endmodule

//--- design/tlb_translate_out.sv
`timescale 1ns/1ns

`include "tlb_config.svh"

module tlb_translate_out import tlb_pkg::*; (
    input  tlb_translate_req_t translate_req,
    input  tlb_entry_t         entries [`TLB_ENTRIES],
    input  tlb_mask_t          hit_onehot,
    output tlb_translate_rsp_t translate_rsp,
    output logic               dirty_refuse,
    output logic               hit_touch,
    output tlb_index_t         hit_index
);

    tlb_entry_t hit_entry;
    logic       hit;
    logic       allowed;

    // --------------------
    // hit select
    // --------------------

    // one-hot or-mux, all zero on a miss
    always_comb begin
        hit_entry = '0;
        hit_index = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (hit_onehot[i]) begin
                hit_entry = tlb_entry_t'(hit_entry | entries[i]);
                hit_index = hit_index | tlb_index_t'(i);
            end
        end
    end

    assign hit       = |hit_onehot;
    assign hit_touch = hit;     // refused hits count as an access too

    // --------------------
    // dirty rule
    // --------------------

    assign allowed      = hit && (!translate_req.rw || hit_entry.dirty);
    assign dirty_refuse = hit && translate_req.rw && !hit_entry.dirty;

    always_comb begin
        translate_rsp.valid = allowed;
        translate_rsp.attr  = hit_entry.attr;
        if (allowed) begin
            translate_rsp.physical = {hit_entry.page,
                                      translate_req.linear[`TLB_OFFSET_W-1:0]};
        end else begin
            translate_rsp.physical = translate_req.linear;  // pass through
        end
    end

endmodule

//--- design/tlb_top.sv
`timescale 1ns/1ns

`include "tlb_config.svh"

module tlb_top import tlb_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush_single,
    input  tlb_addr_t          flush_address,
    input  logic               flush_all,
    input  tlb_write_req_t     write_req,
    input  tlb_translate_req_t translate_req,
    output tlb_translate_rsp_t translate_rsp
);

    tlb_entry_t entries [`TLB_ENTRIES];
    tlb_mask_t  valid_mask;
    tlb_mask_t  hit_onehot;
    tlb_mask_t  write_onehot;
    tlb_entry_t write_entry;
    logic       write_touch;
    tlb_index_t write_index;
    tlb_index_t victim_index;
    logic       hit_touch;
    tlb_index_t hit_index;
    logic       dirty_refuse;

    // --------------------
    // write path
    // --------------------

    tlb_fill_select u_fill_select (
        .write_req    (write_req),
        .valid_mask   (valid_mask),
        .victim_index (victim_index),
        .write_onehot (write_onehot),
        .write_entry  (write_entry),
        .write_touch  (write_touch),
        .write_index  (write_index)
    );

    tlb_plru_tree u_plru_tree (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_all    (flush_all),
        .write_touch  (write_touch),
        .write_index  (write_index),
        .hit_touch    (hit_touch),
        .hit_index    (hit_index),
        .victim_index (victim_index)
    );

    // --------------------
    // storage and lookup
    // --------------------

    tlb_entry_array u_entry_array (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_single  (flush_single),
        .flush_address (flush_address),
        .flush_all     (flush_all),
        .write_onehot  (write_onehot),
        .write_entry   (write_entry),
        .translate_req (translate_req),
        .dirty_refuse  (dirty_refuse),
        .entries       (entries),
        .valid_mask    (valid_mask),
        .hit_onehot    (hit_onehot)
    );

    tlb_translate_out u_translate_out (
        .translate_req (translate_req),
        .entries       (entries),
        .hit_onehot    (hit_onehot),
        .translate_rsp (translate_rsp),
        .dirty_refuse  (dirty_refuse),
        .hit_touch     (hit_touch),
        .hit_index     (hit_index)
    );

endmodule

//--- tb/tlb_tb.sv
`timescale 1ns/1ns

`include "tlb_config.svh"

module tlb_tb import tlb_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 4000;   // far above the ~240 cycles the tests take
    localparam int OFFSET_W = `TLB_OFFSET_W;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               flush_single;
    tlb_addr_t          flush_address;
    logic               flush_all;
    tlb_write_req_t     write_req;
    tlb_translate_req_t translate_req;
    tlb_translate_rsp_t translate_rsp;

    // --------------------
    // reference model
    // --------------------
    logic      m_valid [`TLB_ENTRIES];
    tlb_page_t m_tag   [`TLB_ENTRIES];
    tlb_page_t m_page  [`TLB_ENTRIES];
    tlb_attr_t m_attr  [`TLB_ENTRIES];
    logic      m_dirty [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:1] m_tree;    // heap from 1, leaves at 32..63

    tlb_page_t   used_tags [$];
    tlb_page_t   fill_tags [5];
    tlb_page_t   dirty_tag;
    tlb_page_t   clean_tag;
    logic [31:0] lfsr_state = 32'hd7b3_a7d7;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    tlb_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_single  (flush_single),
        .flush_address (flush_address),
        .flush_all     (flush_all),
        .write_req     (write_req),
        .translate_req (translate_req),
        .translate_rsp (translate_rsp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int b = 0; b < n; b++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    // never hands out a tag twice
    function automatic tlb_page_t fresh_tag();
        tlb_page_t tag;
        logic      seen;
        seen = 1'b1;
        while (seen) begin
            tag  = tlb_page_t'(rand_bits(`TLB_PAGE_W));
            seen = 1'b0;
            foreach (used_tags[i]) begin
                if (used_tags[i] == tag) seen = 1'b1;
            end
        end
        used_tags.push_back(tag);
        return tag;
    endfunction

    function automatic tlb_addr_t page_addr(input tlb_page_t tag);
        return {tag, OFFSET_W'(rand_bits(OFFSET_W))};   // random offset in the page
    endfunction

    function automatic tlb_index_t tree_victim();
        int k;
        k = 1;
        while (k < `TLB_ENTRIES) begin
            k = 2 * k + int'(m_tree[k]);
        end
        return tlb_index_t'(k - `TLB_ENTRIES);
    endfunction

    task automatic tree_touch(input tlb_index_t idx);
        int k;
        k = int'(idx) + `TLB_ENTRIES;
        while (k > 1) begin
            m_tree[k / 2] = (k % 2 == 0);   // came from the left, point right
            k = k / 2;
        end
    endtask

    function automatic tlb_index_t target_slot();
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!m_valid[i]) return tlb_index_t'(i);
        end
        return tree_victim();
    endfunction

    function automatic int find_entry(input tlb_page_t tag);
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (m_valid[i] && m_tag[i] == tag) return i;
        end
        return -1;
    endfunction

    // --------------------
    // checks and bus ops
    // --------------------
    task automatic check_rsp(input string name, input tlb_translate_rsp_t expected,
                             input tlb_translate_rsp_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_index(input string name, input tlb_index_t expected,
                               input tlb_index_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected slot %0d, actual slot %0d", name, expected, actual);
        end
    endtask

    task automatic clear_inputs();
        flush_single  = 1'b0;
        flush_address = '0;
        flush_all     = 1'b0;
        write_req     = '0;
        translate_req = '0;
    endtask

    task automatic write_page(input string name, input tlb_page_t tag, input logic dirty);
        tlb_index_t slot;
        slot = target_slot();
        @(negedge clk);
        write_req.write_do = 1'b1;
        write_req.linear   = page_addr(tag);
        write_req.physical = rand_bits(32);
        write_req.attr     = tlb_attr_t'(4'(rand_bits(4)));
        write_req.dirty    = dirty;
        #10;
        check_index(name, slot, DUT.write_index);
        m_valid[slot] = 1'b1;
        m_tag[slot]   = tag;
        m_page[slot]  = write_req.physical[`TLB_ADDR_W-1:`TLB_OFFSET_W];
        m_attr[slot]  = write_req.attr;
        m_dirty[slot] = dirty;
        tree_touch(slot);
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic lookup(input string name, input tlb_addr_t linear, input logic rw);
        tlb_translate_rsp_t expected;
        int                 hit;
        hit               = find_entry(linear[`TLB_ADDR_W-1:`TLB_OFFSET_W]);
        expected.valid    = 1'b0;
        expected.physical = linear;
        expected.attr     = '0;
        if (hit >= 0) begin
            expected.attr = m_attr[hit];
            if (!rw || m_dirty[hit]) begin
                expected.valid    = 1'b1;
                expected.physical = {m_page[hit], linear[`TLB_OFFSET_W-1:0]};
            end else begin
                m_valid[hit] = 1'b0;    // refused write, entry dropped
            end
            tree_touch(tlb_index_t'(hit));
        end
        @(negedge clk);
        translate_req.translate_do = 1'b1;
        translate_req.linear       = linear;
        translate_req.rw           = rw;
        #10;
        check_rsp(name, expected, translate_rsp);
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic drop_page(input tlb_page_t tag);
        int hit;
        hit = find_entry(tag);
        if (hit >= 0) m_valid[hit] = 1'b0;
        @(negedge clk);
        flush_single  = 1'b1;
        flush_address = page_addr(tag);
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic flush_everything();
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        m_tree = '0;
        @(negedge clk);
        flush_all = 1'b1;
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) $display("test %s passed", name);
        else $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic after_reset();
        int start;
        start = errors;
        for (int n = 0; n < 6; n++) lookup("after_reset", rand_bits(32), 1'(rand_bits(1)));
        report_test("after_reset", start);
    endtask

    task automatic fill_and_hit();
        int start;
        start = errors;
        for (int n = 0; n < 5; n++) begin
            fill_tags[n] = fresh_tag();
            write_page("fill_and_hit", fill_tags[n], 1'b0);
        end
        for (int n = 0; n < 5; n++) lookup("fill_and_hit", page_addr(fill_tags[n]), 1'b0);
        report_test("fill_and_hit", start);
    endtask

    task automatic dirty_rule();
        int start;
        start     = errors;
        dirty_tag = fresh_tag();
        clean_tag = fresh_tag();
        write_page("dirty_rule", dirty_tag, 1'b1);
        write_page("dirty_rule", clean_tag, 1'b0);
        lookup("dirty_rule", page_addr(dirty_tag), 1'b1);
        lookup("dirty_rule", page_addr(clean_tag), 1'b1);  // refused
        lookup("dirty_rule", page_addr(clean_tag), 1'b0);  // gone now
        report_test("dirty_rule", start);
    endtask

    task automatic invalidation();
        int        start;
        tlb_page_t new_tag;
        start   = errors;
        new_tag = fresh_tag();
        drop_page(fill_tags[2]);
        lookup("invalidation", page_addr(fill_tags[2]), 1'b0);
        write_page("invalidation", new_tag, 1'b0);  // takes the freed slot
        lookup("invalidation", page_addr(new_tag), 1'b0);
        lookup("invalidation", page_addr(dirty_tag), 1'b1);
        foreach (fill_tags[n]) lookup("invalidation", page_addr(fill_tags[n]), 1'b0);
        flush_everything();
        foreach (fill_tags[n]) lookup("invalidation", page_addr(fill_tags[n]), 1'b0);
        lookup("invalidation", page_addr(dirty_tag), 1'b0);
        lookup("invalidation", page_addr(new_tag), 1'b0);
        report_test("invalidation", start);
    endtask

    task automatic replacement();
        int         start;
        int         subset [5];
        tlb_index_t victim;
        tlb_page_t  old_tag;
        start  = errors;
        subset = '{3, 17, 8, 30, 12};
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            write_page("replacement", fresh_tag(), 1'(rand_bits(1)));
        end
        foreach (subset[i]) lookup("replacement", page_addr(m_tag[subset[i]]), 1'b0);
        victim  = tree_victim();
        old_tag = m_tag[victim];
        write_page("replacement", fresh_tag(), 1'b0);   // slot check covers the victim
        lookup("replacement", page_addr(old_tag), 1'b0);
        // next victim follows from the touch of that write
        victim  = tree_victim();
        old_tag = m_tag[victim];
        write_page("replacement", fresh_tag(), 1'b0);
        lookup("replacement", page_addr(old_tag), 1'b0);
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            lookup("replacement", page_addr(m_tag[i]), 1'b0);
        end
        report_test("replacement", start);
    endtask

    initial begin
        clear_inputs();
        rst_n = 1'b0;
        foreach (m_valid[i]) m_valid[i] = 1'b0;
        m_tree = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        after_reset();
        fill_and_hit();
        dirty_rule();
        invalidation();
        replacement();
        @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+design
design/tlb_pkg.sv
design/tlb_fill_select.sv
design/tlb_plru_tree.sv
design/tlb_entry_array.sv
design/tlb_translate_out.sv
design/tlb_top.sv
tb/tlb_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tlb testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tlb_tb -f files.f -o tlb_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/tlb_sim); then
    printf '%s\n' "$out"
    echo "simulation exited with an error status"
    exit 1
fi

printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
fi

echo "simulation reported failures"
exit 1
